// ==== rtl/cpu_types_pkg.sv ====
// Shared types for the processor memory side.
// Word, instruction cache geometry and frame layout, plus the
// request/response bundles between datapath, icache, memory
// controller and RAM.

package cpu_types_pkg;

  // basic data/instruction word
  typedef logic [31:0] word_t;

  // icache geometry, 16 one-word frames
  localparam int ITAG_W        = 26;
  localparam int IIDX_W        = 4;
  localparam int IBYT_W        = 2;
  localparam int ICACHE_FRAMES = 1 << IIDX_W;

  // instruction address split into cache fields
  typedef struct packed {
    logic [ITAG_W-1:0] tag;
    logic [IIDX_W-1:0] idx;
    logic [IBYT_W-1:0] bytoff;
  } icache_fields_t;

  // same address word, read raw or as cache fields
  typedef union packed {
    word_t          raw;
    icache_fields_t fields;
  } icache_addr_u;

  // one cache frame, 59 bits
  typedef struct packed {
    logic              valid;
    logic [ITAG_W-1:0] tag;
    word_t             data;
  } icache_frame_t;

  // datapath <-> icache
  typedef struct packed {
    logic  imemREN;
    word_t imemaddr;
  } iport_req_t;

  typedef struct packed {
    logic  ihit;
    word_t imemload;
  } iport_resp_t;

  // datapath <-> memory controller, uncached data port
  typedef struct packed {
    logic  dmemREN;
    logic  dmemWEN;
    word_t dmemaddr;
    word_t dmemstore;
  } dport_req_t;

  typedef struct packed {
    logic  dhit;
    word_t dmemload;
  } dport_resp_t;

  // icache <-> memory controller fill path
  typedef struct packed {
    logic  iREN;
    word_t iaddr;
  } imem_req_t;

  typedef struct packed {
    logic  iwait;
    word_t iload;
  } imem_resp_t;

  // memory controller <-> RAM
  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t store;
  } ram_req_t;

  typedef struct packed {
    logic  rwait;
    word_t load;
  } ram_resp_t;

endpackage

// ==== rtl/icache.sv ====
// Direct-mapped instruction cache, 16 one-word frames.
// Hit is combinational on tag match with a valid frame.
// A miss moves the idle/request controller into REQUEST, which
// asks the memory controller for the word and fills the frame.

`timescale 1ns/1ns

module icache (
  input  logic                      CLK,
  input  logic                      nRST,
  input  cpu_types_pkg::iport_req_t  ireq,
  output cpu_types_pkg::iport_resp_t iresp,
  output cpu_types_pkg::imem_req_t   mreq,
  input  cpu_types_pkg::imem_resp_t  mresp
);

  // fill controller states
  typedef enum logic {
    IDLE    = 1'b0,
    REQUEST = 1'b1
  } state_t;

  state_t state_reg;
  state_t state_nxt;

  // frame storage
  cpu_types_pkg::icache_frame_t frames [cpu_types_pkg::ICACHE_FRAMES];
  cpu_types_pkg::icache_frame_t cur_frame;

  // address decoded into tag/index/byte offset
  cpu_types_pkg::icache_addr_u  iaddr;

  logic tag_match;
  logic hit;
  logic fill_wen;

  assign iaddr.raw = ireq.imemaddr;
  assign cur_frame = frames[iaddr.fields.idx];

  // tag compare against the indexed frame
  assign tag_match = cur_frame.valid && (cur_frame.tag == iaddr.fields.tag);

  // no hit while the frame is being written
  assign hit = ireq.imemREN && tag_match && !fill_wen;

  // datapath response
  assign iresp.ihit     = hit;
  assign iresp.imemload = cur_frame.data;

  // fill request always carries the fetch address
  assign mreq.iaddr = ireq.imemaddr;

  // next state
  always_comb begin
    state_nxt = state_reg;
    case (state_reg)
      IDLE: begin
        // fetch asked for and not in cache
        if (ireq.imemREN && !hit) begin
          state_nxt = REQUEST;
        end
      end
      REQUEST: begin
        // word arrives when the wait drops
        if (!mresp.iwait) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  // controller outputs
  always_comb begin
    mreq.iREN = 1'b0;
    fill_wen  = 1'b0;
    if (state_reg == REQUEST) begin
      mreq.iREN = 1'b1;
      // write the frame in the cycle memory answers
      fill_wen  = !mresp.iwait;
    end
  end

  // controller state register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state_reg <= IDLE;
    end else begin
      state_reg <= state_nxt;
    end
  end

  // frame array, all invalid out of reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < cpu_types_pkg::ICACHE_FRAMES; i++) begin
        frames[i] <= '0;
      end
    end else if (fill_wen) begin
      // load data, tag and valid together
      frames[iaddr.fields.idx].valid <= 1'b1;
      frames[iaddr.fields.idx].tag   <= iaddr.fields.tag;
      frames[iaddr.fields.idx].data  <= mresp.iload;
    end
  end

endmodule

// ==== rtl/memory_control.sv ====
// Memory controller between the icache fill path and the
// uncached data port. The data port wins whenever it asks;
// the RAM wait and load are steered back to the selected side
// while the other side is held waiting.

`timescale 1ns/1ns

module memory_control (
  input  cpu_types_pkg::imem_req_t   ireq,
  output cpu_types_pkg::imem_resp_t  iresp,
  input  cpu_types_pkg::dport_req_t  dreq,
  output cpu_types_pkg::dport_resp_t dresp,
  output cpu_types_pkg::ram_req_t    rreq,
  input  cpu_types_pkg::ram_resp_t   rresp
);

  // data access owns the RAM this cycle
  logic dsel;

  assign dsel = dreq.dmemREN || dreq.dmemWEN;

  // request mux toward RAM
  always_comb begin
    rreq = '0;
    if (dsel) begin
      rreq.ren   = dreq.dmemREN;
      rreq.wen   = dreq.dmemWEN;
      rreq.addr  = dreq.dmemaddr;
      rreq.store = dreq.dmemstore;
    end else begin
      // instruction fills are read only
      rreq.ren   = ireq.iREN;
      rreq.wen   = 1'b0;
      rreq.addr  = ireq.iaddr;
      rreq.store = '0;
    end
  end

  // data side response
  always_comb begin
    dresp.dmemload = rresp.load;
    dresp.dhit     = 1'b0;
    if (dsel) begin
      // done in the cycle RAM stops waiting
      dresp.dhit = !rresp.rwait;
    end
  end

  // instruction side response
  always_comb begin
    iresp.iload = rresp.load;
    if (dsel) begin
      // fill stalled behind the data access
      iresp.iwait = 1'b1;
    end else begin
      iresp.iwait = rresp.rwait;
    end
  end

endmodule

// ==== rtl/main_ram.sv ====
// Word-wide RAM model, 256 words addressed by bits 9:2.
// A request held steady completes RAM_LATENCY cycles after it
// first shows up; rwait drops in that cycle and a write commits
// on the closing edge. The count restarts on any change.

`timescale 1ns/1ns

module main_ram #(
  parameter int unsigned RAM_LATENCY = 3
) (
  input  logic                    CLK,
  input  logic                    nRST,
  input  cpu_types_pkg::ram_req_t  req,
  output cpu_types_pkg::ram_resp_t resp
);

  localparam int WORDS = 256;
  localparam int CNT_W = $clog2(RAM_LATENCY + 1);

  cpu_types_pkg::word_t mem [WORDS];

  // request seen in the previous cycle
  cpu_types_pkg::ram_req_t last_req;

  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] held;
  logic [7:0]       widx;
  logic             active;
  logic             same;
  logic             done;

  assign widx   = req.addr[9:2];
  assign active = req.ren || req.wen;

  // same access as last cycle, so keep counting
  assign same = active && (last_req.ren || last_req.wen)
                && (req.ren == last_req.ren)
                && (req.wen == last_req.wen)
                && (req.addr == last_req.addr);

  // cycles this request has been held, this one included
  assign held = same ? count + 1'b1 : CNT_W'(1);

  assign done = active && (held >= RAM_LATENCY);

  assign resp.rwait = active && !done;
  assign resp.load  = mem[widx];

  // latency tracking
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count    <= '0;
      last_req <= '0;
    end else begin
      last_req <= req;
      // restart after completion so a held request repeats
      if (!active || done) begin
        count <= '0;
      end else begin
        count <= held;
      end
    end
  end

  // storage, cleared on reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (done && req.wen) begin
      mem[widx] <= req.store;
    end
  end

endmodule

// ==== rtl/caches_top.sv ====
// Top of the memory side.
// Joins the instruction cache, the memory controller and the
// shared RAM; the datapath sees the icache port and the
// uncached data port.

`timescale 1ns/1ns

module caches_top #(
  parameter int unsigned RAM_LATENCY = 3
) (
  input  logic                       CLK,
  input  logic                       nRST,
  input  cpu_types_pkg::iport_req_t  ireq,
  output cpu_types_pkg::iport_resp_t iresp,
  input  cpu_types_pkg::dport_req_t  dreq,
  output cpu_types_pkg::dport_resp_t dresp
);

  // icache fill path
  cpu_types_pkg::imem_req_t  fill_req;
  cpu_types_pkg::imem_resp_t fill_resp;

  // controller to RAM
  cpu_types_pkg::ram_req_t   ram_req;
  cpu_types_pkg::ram_resp_t  ram_resp;

  icache u_icache (
    .CLK   (CLK),
    .nRST  (nRST),
    .ireq  (ireq),
    .iresp (iresp),
    .mreq  (fill_req),
    .mresp (fill_resp)
  );

  memory_control u_memory_control (
    .ireq  (fill_req),
    .iresp (fill_resp),
    .dreq  (dreq),
    .dresp (dresp),
    .rreq  (ram_req),
    .rresp (ram_resp)
  );

  main_ram #(
    .RAM_LATENCY (RAM_LATENCY)
  ) u_main_ram (
    .CLK  (CLK),
    .nRST (nRST),
    .req  (ram_req),
    .resp (ram_resp)
  );

endmodule

// ==== dv/cpu_clock_gen.sv ====
// Clock and reset source for the memory side testbench.
// Free-running clock, reset held low for a fixed count of
// cycles and released on a falling edge.

`timescale 1ns/1ns

module cpu_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // release away from the rising edge
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

// ==== dv/caches_tb.sv ====
// Testbench for the processor memory side.
// Applies a table of instruction fetches and data accesses and
// checks each answer against a shadow memory and a small model
// of the direct-mapped cache tags.

`timescale 1ns/1ns

module caches_tb;

  localparam int unsigned RAM_LATENCY = 3;
  localparam int DRIVE_DLY   = 10;
  localparam int WAIT_LIMIT  = 50;
  localparam int RESET_LIMIT = 20;

  typedef enum logic { PORT_I, PORT_D } port_e;
  typedef enum logic { OP_READ, OP_WRITE } op_e;

  // one row of the stimulus table
  typedef struct packed {
    port_e                port;
    op_e                  op;
    logic                 overlap;  // data write injected during the fill
    logic                 exp_hit;  // ihit in the first cycle
    cpu_types_pkg::word_t addr;
    cpu_types_pkg::word_t store;
    cpu_types_pkg::word_t expected;
  } entry_t;

  logic CLK;
  logic nRST;

  cpu_types_pkg::iport_req_t  ireq;
  cpu_types_pkg::iport_resp_t iresp;
  cpu_types_pkg::dport_req_t  dreq;
  cpu_types_pkg::dport_resp_t dresp;

  entry_t table_q[$];

  // reference memory contents
  cpu_types_pkg::word_t shadow [256];
  // what the cache should hold per index
  logic                               model_valid [cpu_types_pkg::ICACHE_FRAMES];
  logic [cpu_types_pkg::ITAG_W-1:0]   model_tag   [cpu_types_pkg::ICACHE_FRAMES];
  cpu_types_pkg::word_t               model_data  [cpu_types_pkg::ICACHE_FRAMES];

  integer seed;

  cpu_clock_gen #(
    .PERIOD       (100),
    .RESET_CYCLES (10)
  ) u_clock_gen (
    .CLK  (CLK),
    .nRST (nRST)
  );

  caches_top #(
    .RAM_LATENCY (RAM_LATENCY)
  ) DUT (
    .CLK   (CLK),
    .nRST  (nRST),
    .ireq  (ireq),
    .iresp (iresp),
    .dreq  (dreq),
    .dresp (dresp)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input cpu_types_pkg::word_t exp,
                            input cpu_types_pkg::word_t act);
    if (act !== exp) begin
      stop_run($sformatf("CHECK FAILED at %0t ns: %s expected %08h actual %08h",
                         $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("CHECK FAILED at %0t ns: %s expected %b actual %b",
                         $time, name, exp, act));
    end
  endtask

  // inputs change a little after the rising edge
  task automatic next_drive();
    @(posedge CLK);
    #DRIVE_DLY;
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (nRST !== 1'b1) begin
      if (n >= RESET_LIMIT) stop_run("reset was never released");
      else begin
        n++;
        @(posedge CLK);
      end
    end
  endtask

  // called at a falling edge, returns at the falling edge of the hit
  task automatic wait_ihit();
    int n;
    n = 0;
    while (iresp.ihit !== 1'b1) begin
      if (n >= WAIT_LIMIT) begin
        stop_run($sformatf("no instruction hit within %0d cycles at %0t ns",
                           WAIT_LIMIT, $time));
      end else begin
        n++;
        @(negedge CLK);
      end
    end
  endtask

  // fetch_held: an instruction miss is pending and must not finish first
  task automatic wait_dhit(input logic fetch_held);
    int n;
    n = 0;
    while (dresp.dhit !== 1'b1) begin
      if (n >= WAIT_LIMIT) begin
        stop_run($sformatf("no data hit within %0d cycles at %0t ns",
                           WAIT_LIMIT, $time));
      end else begin
        if (fetch_held) check_flag("iresp.ihit", 1'b0, iresp.ihit);
        n++;
        @(negedge CLK);
      end
    end
    if (fetch_held) check_flag("iresp.ihit", 1'b0, iresp.ihit);
  endtask

  // append a row, expected values follow the shadow and tag model
  task automatic add_entry(input port_e port, input op_e op,
                           input cpu_types_pkg::word_t addr, input logic overlap);
    entry_t                           e;
    logic [7:0]                       widx;
    logic [cpu_types_pkg::IIDX_W-1:0] idx;
    logic [cpu_types_pkg::ITAG_W-1:0] tag;
    e         = '0;
    e.port    = port;
    e.op      = op;
    e.addr    = addr;
    e.overlap = overlap;
    widx = addr[9:2];
    idx  = addr[cpu_types_pkg::IBYT_W +: cpu_types_pkg::IIDX_W];
    tag  = addr[31 -: cpu_types_pkg::ITAG_W];
    if (op == OP_WRITE || overlap) e.store = $random(seed);
    if (port == PORT_D) begin
      if (op == OP_WRITE) shadow[widx] = e.store;
      e.expected = shadow[widx];
    end else begin
      // injected write lands before the fill reads memory
      if (overlap) shadow[widx] = e.store;
      e.exp_hit = model_valid[idx] && (model_tag[idx] == tag);
      if (e.exp_hit) e.expected = model_data[idx];
      else begin
        e.expected       = shadow[widx];
        model_valid[idx] = 1'b1;
        model_tag[idx]   = tag;
        model_data[idx]  = shadow[widx];
      end
    end
    table_q.push_back(e);
  endtask

  task automatic build_table();
    foreach (shadow[i]) shadow[i] = '0;
    foreach (model_valid[i]) model_valid[i] = 1'b0;
    // cold fetch right after reset
    add_entry(PORT_I, OP_READ,  32'h0000_0020, 1'b0);
    // data writes, then reads back
    add_entry(PORT_D, OP_WRITE, 32'h0000_0010, 1'b0);
    add_entry(PORT_D, OP_WRITE, 32'h0000_0050, 1'b0);
    add_entry(PORT_D, OP_WRITE, 32'h0000_0100, 1'b0);
    add_entry(PORT_D, OP_WRITE, 32'h0000_0204, 1'b0);
    add_entry(PORT_D, OP_READ,  32'h0000_0010, 1'b0);
    add_entry(PORT_D, OP_READ,  32'h0000_0050, 1'b0);
    add_entry(PORT_D, OP_READ,  32'h0000_0100, 1'b0);
    add_entry(PORT_D, OP_READ,  32'h0000_0204, 1'b0);
    // miss then hit
    add_entry(PORT_I, OP_READ,  32'h0000_0010, 1'b0);
    add_entry(PORT_I, OP_READ,  32'h0000_0010, 1'b0);
    // 0x010 and 0x050 share index 4
    add_entry(PORT_I, OP_READ,  32'h0000_0050, 1'b0);
    add_entry(PORT_I, OP_READ,  32'h0000_0010, 1'b0);
    add_entry(PORT_I, OP_READ,  32'h0000_0100, 1'b0);
    add_entry(PORT_I, OP_READ,  32'h0000_0100, 1'b0);
    add_entry(PORT_D, OP_WRITE, 32'h0000_0204, 1'b0);
    add_entry(PORT_D, OP_READ,  32'h0000_0204, 1'b0);
    // data write to the missed word while the fill waits
    add_entry(PORT_I, OP_READ,  32'h0000_03f8, 1'b1);
    add_entry(PORT_I, OP_READ,  32'h0000_03f8, 1'b0);
    add_entry(PORT_I, OP_READ,  32'h0000_0204, 1'b0);
    add_entry(PORT_I, OP_READ,  32'h0000_0050, 1'b0);
  endtask

  task automatic run_entry(input entry_t e);
    next_drive();
    if (e.port == PORT_D) begin
      dreq.dmemREN   = (e.op == OP_READ);
      dreq.dmemWEN   = (e.op == OP_WRITE);
      dreq.dmemaddr  = e.addr;
      dreq.dmemstore = e.store;
      @(negedge CLK);
      wait_dhit(1'b0);
      if (e.op == OP_READ) check_word("dresp.dmemload", e.expected, dresp.dmemload);
    end else begin
      ireq.imemREN  = 1'b1;
      ireq.imemaddr = e.addr;
      @(negedge CLK);
      // hit or miss shows in the very first cycle
      check_flag("iresp.ihit", e.exp_hit, iresp.ihit);
      if (e.overlap) begin
        next_drive();
        dreq.dmemWEN   = 1'b1;
        dreq.dmemaddr  = e.addr;
        dreq.dmemstore = e.store;
        @(negedge CLK);
        wait_dhit(1'b1);
        next_drive();
        dreq = '0;
        @(negedge CLK);
      end
      wait_ihit();
      check_word("iresp.imemload", e.expected, iresp.imemload);
    end
    // one idle cycle between rows
    next_drive();
    ireq = '0;
    dreq = '0;
  endtask

  initial begin
    ireq = '0;
    dreq = '0;
    seed = 32'h6d29_be6d;
    build_table();
    wait_reset();
    foreach (table_q[i]) run_entry(table_q[i]);
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== project.f ====
rtl/cpu_types_pkg.sv
rtl/icache.sv
rtl/memory_control.sv
rtl/main_ram.sv
rtl/caches_top.sv
dv/cpu_clock_gen.sv
dv/caches_tb.sv

// ==== Makefile ====
# Verilator build for the memory side testbench

VERILATOR ?= verilator
TOP       := caches_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -Wno-fatal -j 0
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the pass/fail result
run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
